/* logic/hdr_pkg.sv */
//----------------------------------------------------------------------
// shared widths, view codes and APB map for the HDR video path
// pixel byte order is red low, blue high; view codes outside the enum show cam0
//----------------------------------------------------------------------
package hdr_pkg;

	// widths with a meaning of their own
	typedef logic [7:0]  chan_t;      // one colour channel
	typedef logic [23:0] pixel_t;     // {blue, green, red}
	typedef logic [63:0] ddr_word_t;  // two pixels per memory word
	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// view selector codes
	typedef enum logic [3:0]
	{
		VIEW_CAM0 = 4'd1,
		VIEW_CAM1 = 4'd2,
		VIEW_HDR  = 4'd3
	} view_t;

	// register map
	localparam apb_addr_t ADDR_VIEW   = 4'h0;  // read/write
	localparam apb_addr_t ADDR_STATUS = 4'h4;  // read only

	localparam view_t VIEW_RESET = VIEW_CAM0;

	// camera reset hold, in sys_clk_b cycles
	localparam int CAM_RESET_CYCLES = 2500;
	localparam int CAM_CNT_W        = $clog2(CAM_RESET_CYCLES);

	// bit positions in the status word
	localparam int STATUS_VIEW_LSB  = 0;
	localparam int STATUS_READY_BIT = 8;

	// per-channel split of a pixel
	localparam int CHAN_W    = $bits(chan_t);
	localparam int PIX_CHANS = $bits(pixel_t) / CHAN_W;

endpackage

/* logic/cam_power_seq.sv */
//----------------------------------------------------------------------
// camera power-up sequence on sys_clk_b; reset held CAM_RESET_CYCLES edges
//----------------------------------------------------------------------
`timescale 1ns/1ps

module cam_power_seq import hdr_pkg::*;
(
	input  logic sys_clk_b,
	input  logic reset_n_b,
	output logic cam_pwdn_o,
	output logic cam_resetb_o
);

	logic                 running;
	logic [CAM_CNT_W-1:0] cnt;
	logic                 done;

	// last counted edge before release
	assign done = running && (cnt == CAM_CNT_W'(CAM_RESET_CYCLES - 1));

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			cam_pwdn_o <= 1'b1;
		else
			cam_pwdn_o <= 1'b0;   // power up on first edge

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			running <= 1'b1;
			cnt     <= '0;
		end
		else if (running)
		begin
			cnt <= cnt + 1'b1;
			if (done)
				running <= 1'b0;  // counter parks here
		end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			cam_resetb_o <= 1'b0;
		else if (done)
			cam_resetb_o <= 1'b1;

	// once released the cameras stay out of reset
	a_resetb_sticky: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		cam_resetb_o |=> cam_resetb_o
	);

endmodule

/* logic/hdr_cfg_regs.sv */
//----------------------------------------------------------------------
// APB slave, zero wait states; unmapped addresses answer with pslverr
//----------------------------------------------------------------------
`timescale 1ns/1ps

module hdr_cfg_regs import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	// APB
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  apb_addr_t paddr_i,
	input  apb_data_t pwdata_i,
	output apb_data_t prdata_o,
	output logic      pready_o,
	output logic      pslverr_o,
	// status sources
	input  view_t     view_act_i,   // <- view_select
	input  logic      cam_ready_i,  // <- cam_power_seq
	output view_t     view_req_o    // -> view_select
);

	logic      access;
	logic      addr_hit;
	apb_data_t status_word;

	assign access   = psel_i && penable_i;
	assign addr_hit = (paddr_i == ADDR_VIEW) || (paddr_i == ADDR_STATUS);

	assign pready_o  = 1'b1;
	assign pslverr_o = access && !addr_hit;

	always_comb
	begin
		status_word = '0;
		status_word[STATUS_VIEW_LSB +: $bits(view_t)] = view_act_i;
		status_word[STATUS_READY_BIT]                 = cam_ready_i;
	end

	// requested view, taken at the next sop
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			view_req_o <= VIEW_RESET;
		else if (access && pwrite_i && (paddr_i == ADDR_VIEW))
			view_req_o <= view_t'(pwdata_i[$bits(view_t)-1:0]);

	// read mux
	always_comb
	begin
		case (paddr_i)
			ADDR_VIEW:
			begin
				prdata_o = '0;
				prdata_o[$bits(view_t)-1:0] = view_req_o;
			end
			ADDR_STATUS:
				prdata_o = status_word;
			default:
				prdata_o = '0;    // error response carries no data
		endcase
	end

	// access phase only follows a selected setup phase
	a_penable_sel: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		penable_i |-> psel_i
	);

	// setup is always followed by access
	a_setup_access: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		(psel_i && !penable_i) |=> (psel_i && penable_i)
	);

endmodule

/* logic/view_select.sv */
//----------------------------------------------------------------------
// view switches only on a valid sop beat; HDR is a truncated channel mean
//----------------------------------------------------------------------
`timescale 1ns/1ps

module view_select import hdr_pkg::*;
(
	input  logic   sys_clk_b,
	input  logic   reset_n_b,
	input  view_t  view_req_i,
	input  pixel_t cam0_pix_i,
	input  pixel_t cam1_pix_i,
	input  logic   pix_valid_i,
	input  logic   pix_sop_i,
	output view_t  view_act_o,
	output pixel_t sel_pix_o,
	output logic   sel_valid_o,
	output logic   sel_sop_o
);

	logic   frame_start;
	view_t  cur_view;
	pixel_t hdr_pix;
	pixel_t mux_pix;

	assign frame_start = pix_valid_i && pix_sop_i;

	// sop beat already uses the new view
	assign cur_view = frame_start ? view_req_i : view_act_o;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
			view_act_o <= VIEW_RESET;
		else if (frame_start)
			view_act_o <= view_req_i;

	// per channel (a + b) >> 1
	always_comb
	begin
		logic [CHAN_W:0] chan_sum;
		chan_sum = '0;
		for (int i = 0; i < PIX_CHANS; i++)
		begin
			chan_sum = {1'b0, cam0_pix_i[i*CHAN_W +: CHAN_W]}
				+ {1'b0, cam1_pix_i[i*CHAN_W +: CHAN_W]};
			hdr_pix[i*CHAN_W +: CHAN_W] = chan_sum[CHAN_W:1];
		end
	end

	always_comb
	begin
		case (cur_view)
			VIEW_CAM1: mux_pix = cam1_pix_i;
			VIEW_HDR:  mux_pix = hdr_pix;
			default:   mux_pix = cam0_pix_i;  // cam0 and unknown codes
		endcase
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			sel_valid_o <= 1'b0;
			sel_sop_o   <= 1'b0;
		end
		else
		begin
			sel_valid_o <= pix_valid_i;
			sel_sop_o   <= frame_start;
		end

	always_ff @(posedge sys_clk_b)
		if (pix_valid_i)
			sel_pix_o <= mux_pix;

	a_sop_valid: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		sel_sop_o |-> sel_valid_o
	);

endmodule

/* logic/ddr_word_pack.sv */
//----------------------------------------------------------------------
// pairs pixels from each sop into one word; an unpaired pixel is dropped
//----------------------------------------------------------------------
`timescale 1ns/1ps

module ddr_word_pack import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	input  pixel_t    sel_pix_i,
	input  logic      sel_valid_i,
	input  logic      sel_sop_i,
	output ddr_word_t ddr_data_o,
	output logic      ddr_valid_o
);

	localparam int PAD_W = $bits(ddr_word_t) / 2 - $bits(pixel_t);

	logic   phase;      // 1 while holding the first pixel of a pair
	pixel_t half_pix;
	logic   pair_done;

	assign pair_done = sel_valid_i && phase && !sel_sop_i;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
		if (!reset_n_b)
		begin
			phase       <= 1'b0;
			ddr_valid_o <= 1'b0;
		end
		else
		begin
			ddr_valid_o <= pair_done;
			if (sel_valid_i)
				phase <= sel_sop_i || !phase;  // sop always starts a new pair
		end

	always_ff @(posedge sys_clk_b)
		if (sel_valid_i && !pair_done)
			half_pix <= sel_pix_i;

	// first pixel high, second low
	always_ff @(posedge sys_clk_b)
		if (pair_done)
			ddr_data_o <= {{PAD_W{1'b0}}, half_pix, {PAD_W{1'b0}}, sel_pix_i};

	a_valid_gap: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		ddr_valid_o |=> !ddr_valid_o
	);

endmodule

/* logic/hdr_video_top.sv */
//----------------------------------------------------------------------
// dual-camera view select and frame-buffer packing, single clock domain
// the pixel stream has no back-pressure; APB has zero wait states
//----------------------------------------------------------------------
`timescale 1ns/1ps

module hdr_video_top import hdr_pkg::*;
(
	input  logic      sys_clk_b,
	input  logic      reset_n_b,
	// APB configuration
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  apb_addr_t paddr_i,
	input  apb_data_t pwdata_i,
	output apb_data_t prdata_o,
	output logic      pready_o,
	output logic      pslverr_o,
	// debayered camera pixels
	input  pixel_t    cam0_pix_i,
	input  pixel_t    cam1_pix_i,
	input  logic      pix_valid_i,
	input  logic      pix_sop_i,
	// frame buffer words
	output ddr_word_t ddr_data_o,
	output logic      ddr_valid_o,
	// camera control pins
	output logic      cam_pwdn_o,
	output logic      cam_resetb_o
);

	view_t  view_req;
	view_t  view_act;
	pixel_t sel_pix;
	logic   sel_valid;
	logic   sel_sop;

	cam_power_seq cam_power_seq_inst
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.cam_pwdn_o   ( cam_pwdn_o   ),
		.cam_resetb_o ( cam_resetb_o )
	);

	hdr_cfg_regs hdr_cfg_regs_inst
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.psel_i       ( psel_i       ),
		.penable_i    ( penable_i    ),
		.pwrite_i     ( pwrite_i     ),
		.paddr_i      ( paddr_i      ),
		.pwdata_i     ( pwdata_i     ),
		.prdata_o     ( prdata_o     ),
		.pready_o     ( pready_o     ),
		.pslverr_o    ( pslverr_o    ),
		.view_act_i   ( view_act     ),
		.cam_ready_i  ( cam_resetb_o ),  // ready once reset released
		.view_req_o   ( view_req     )
	);

	view_select view_select_inst
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.view_req_i   ( view_req     ),
		.cam0_pix_i   ( cam0_pix_i   ),
		.cam1_pix_i   ( cam1_pix_i   ),
		.pix_valid_i  ( pix_valid_i  ),
		.pix_sop_i    ( pix_sop_i    ),
		.view_act_o   ( view_act     ),
		.sel_pix_o    ( sel_pix      ),
		.sel_valid_o  ( sel_valid    ),
		.sel_sop_o    ( sel_sop      )
	);

	ddr_word_pack ddr_word_pack_inst
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.sel_pix_i    ( sel_pix      ),
		.sel_valid_i  ( sel_valid    ),
		.sel_sop_i    ( sel_sop      ),
		.ddr_data_o   ( ddr_data_o   ),
		.ddr_valid_o  ( ddr_valid_o  )
	);

endmodule

/* test/tb_hdr_video.sv */
//----------------------------------------------------------------------
// random frames from a fixed LFSR seed; words checked against a local model
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_hdr_video import hdr_pkg::*; ();

	localparam int MAX_FRAMES  = 12;
	localparam int CYCLE_LIMIT = CAM_RESET_CYCLES + MAX_FRAMES * (64 * 4 + 40) + 1000;

	logic      sys_clk_b;
	logic      reset_n_b;
	logic      psel_i, penable_i, pwrite_i;
	apb_addr_t paddr_i;
	apb_data_t pwdata_i;
	apb_data_t prdata_o;
	logic      pready_o, pslverr_o;
	pixel_t    cam0_pix_i, cam1_pix_i;
	logic      pix_valid_i, pix_sop_i;
	ddr_word_t ddr_data_o;
	logic      ddr_valid_o;
	logic      cam_pwdn_o, cam_resetb_o;

	logic [31:0] lfsr = 32'h7697_fdd4;
	int          cyc = 0;          // edges since reset release
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic        prev_valid = 1'b0;

	// model state
	logic [3:0] model_req = VIEW_RESET;
	logic [3:0] model_act = VIEW_RESET;
	logic       model_phase = 1'b0;
	pixel_t     model_half;
	ddr_word_t  exp_words[$];
	int         exp_cycles[$];

	hdr_video_top dut0
	(
		.sys_clk_b    ( sys_clk_b    ),
		.reset_n_b    ( reset_n_b    ),
		.psel_i       ( psel_i       ),
		.penable_i    ( penable_i    ),
		.pwrite_i     ( pwrite_i     ),
		.paddr_i      ( paddr_i      ),
		.pwdata_i     ( pwdata_i     ),
		.prdata_o     ( prdata_o     ),
		.pready_o     ( pready_o     ),
		.pslverr_o    ( pslverr_o    ),
		.cam0_pix_i   ( cam0_pix_i   ),
		.cam1_pix_i   ( cam1_pix_i   ),
		.pix_valid_i  ( pix_valid_i  ),
		.pix_sop_i    ( pix_sop_i    ),
		.ddr_data_o   ( ddr_data_o   ),
		.ddr_valid_o  ( ddr_valid_o  ),
		.cam_pwdn_o   ( cam_pwdn_o   ),
		.cam_resetb_o ( cam_resetb_o )
	);

	initial
	begin
		sys_clk_b = 1'b0;
		forever #10 sys_clk_b = ~sys_clk_b;
	end

	always @(posedge sys_clk_b)
		if (reset_n_b)
			cyc <= cyc + 1;

	// taps 32,22,2,1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// cam1, channel mean or cam0 for anything else
	function automatic pixel_t select_expected(input logic [3:0] view, input pixel_t a,
		input pixel_t b);
		pixel_t     res;
		logic [8:0] sum;
		res = a;
		if (view == 4'd2)
			res = b;
		else if (view == 4'd3)
			for (int i = 0; i < 3; i++)
			begin
				sum = a[i*8 +: 8] + b[i*8 +: 8];
				res[i*8 +: 8] = sum >> 1;
			end
		return res;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		$display("Fail %0t ns: %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic model_beat(input pixel_t p0, input pixel_t p1, input logic sop);
		pixel_t s;
		if (sop)
			model_act = model_req;
		s = select_expected(model_act, p0, p1);
		if (sop || !model_phase)
		begin
			model_half  = s;
			model_phase = 1'b1;
		end
		else
		begin
			exp_words.push_back({8'h00, model_half, 8'h00, s});
			exp_cycles.push_back(cyc + 2);   // captured next edge, word one later
			model_phase = 1'b0;
		end
	endtask

	always @(negedge sys_clk_b)
		if (reset_n_b)
		begin
			if (ddr_valid_o && prev_valid)
				report_problem("ddr_valid_o high on two consecutive cycles");
			if (ddr_valid_o && exp_words.size() == 0)
				report_problem("ddr_valid_o set with no word expected");
			else if (ddr_valid_o)
			begin
				if (ddr_data_o !== exp_words[0])
					report_mismatch("ddr_data_o", exp_words[0], ddr_data_o);
				if (cyc != exp_cycles[0])
					report_mismatch("ddr_valid_o cycle", exp_cycles[0], cyc);
				void'(exp_words.pop_front());
				void'(exp_cycles.pop_front());
			end
			prev_valid = ddr_valid_o;
		end

	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		@(posedge sys_clk_b);
		#2;
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = wdata;
		@(posedge sys_clk_b);
		#2;
		penable_i = 1'b1;
		#5;
		rdata = prdata_o;
		err   = pslverr_o;
		if (pready_o !== 1'b1)
			report_mismatch("pready_o", 1, pready_o);
		@(posedge sys_clk_b);
		#2;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		logic      exp_err;
		exp_err = !(addr == ADDR_VIEW || addr == ADDR_STATUS);
		apb_access(1'b1, addr, data, rd, err);
		if (err !== exp_err)
			report_mismatch("pslverr_o", exp_err, err);
		if (addr == ADDR_VIEW)
			model_req = data[3:0];
	endtask

	task automatic apb_check_read(input apb_addr_t addr, input apb_data_t exp);
		apb_data_t rd;
		logic      err;
		logic      exp_err;
		exp_err = !(addr == ADDR_VIEW || addr == ADDR_STATUS);
		apb_access(1'b0, addr, '0, rd, err);
		if (err !== exp_err)
			report_mismatch("pslverr_o", exp_err, err);
		if (rd !== exp)
			report_mismatch("prdata_o", exp, rd);
	endtask

	// wr_at < 0 means no view write during the frame
	task automatic run_frame(input int len, input int wr_at, input logic [3:0] wr_code);
		int     beats;
		int     c;
		logic   v;
		logic   sop;
		pixel_t p0;
		pixel_t p1;
		beats = 0;
		c     = 0;
		while (beats < len)
		begin
			@(posedge sys_clk_b);
			#2;
			v   = (rand_bits(2) != 0);       // idle one beat in four
			p0  = rand_bits(24);
			p1  = rand_bits(24);
			sop = (beats == 0);              // also set on idle beats before the first
			cam0_pix_i  = p0;
			cam1_pix_i  = p1;
			pix_valid_i = v;
			pix_sop_i   = sop;
			if (wr_at >= 0 && c == wr_at)
			begin
				psel_i   = 1'b1;
				pwrite_i = 1'b1;
				paddr_i  = ADDR_VIEW;
				pwdata_i = {28'h0, wr_code};
			end
			else if (wr_at >= 0 && c == wr_at + 1)
				penable_i = 1'b1;
			else if (wr_at >= 0 && c == wr_at + 2)
			begin
				psel_i    = 1'b0;
				penable_i = 1'b0;
				pwrite_i  = 1'b0;
			end
			if (v)
			begin
				model_beat(p0, p1, v && sop);
				beats++;
			end
			if (wr_at >= 0 && c == wr_at + 1)
				model_req = wr_code;         // takes effect at this access edge
			c++;
		end
		@(posedge sys_clk_b);
		#2;
		pix_valid_i = 1'b0;
		pix_sop_i   = 1'b0;
	endtask

	task automatic drain_words();
		int n;
		n = 0;
		while (exp_words.size() != 0 && n < 8)
		begin
			@(negedge sys_clk_b);
			n++;
		end
		if (exp_words.size() != 0)
			report_problem("expected memory words never appeared");
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - errs_before);
		end
	endtask

	always @(posedge sys_clk_b)
		if (cyc > CYCLE_LIMIT)
		begin
			$display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end

	initial
	begin
		int         e0;
		logic [3:0] codes [4];
		codes = '{4'd1, 4'd2, 4'd3, 4'hB};
		reset_n_b   = 1'b0;
		psel_i      = 1'b0;
		penable_i   = 1'b0;
		pwrite_i    = 1'b0;
		paddr_i     = '0;
		pwdata_i    = '0;
		cam0_pix_i  = '0;
		cam1_pix_i  = '0;
		pix_valid_i = 1'b0;
		pix_sop_i   = 1'b0;

		// camera sequence
		e0 = errors;
		@(posedge sys_clk_b);
		#2;
		if (cam_pwdn_o !== 1'b1)
			report_mismatch("cam_pwdn_o", 1, cam_pwdn_o);
		if (cam_resetb_o !== 1'b0)
			report_mismatch("cam_resetb_o", 0, cam_resetb_o);
		repeat (2) @(posedge sys_clk_b);
		#2;
		reset_n_b = 1'b1;
		@(negedge sys_clk_b);
		if (cam_pwdn_o !== 1'b1)
			report_mismatch("cam_pwdn_o", 1, cam_pwdn_o);   // no edge since release
		@(negedge sys_clk_b);
		if (cam_pwdn_o !== 1'b0)
			report_mismatch("cam_pwdn_o", 0, cam_pwdn_o);
		apb_check_read(ADDR_STATUS, 32'h001);   // not ready yet
		while (cyc < CAM_RESET_CYCLES + 3)
		begin
			@(negedge sys_clk_b);
			if (cam_pwdn_o !== 1'b0)
				report_mismatch("cam_pwdn_o", 0, cam_pwdn_o);
			if (cam_resetb_o !== (cyc >= CAM_RESET_CYCLES))
				report_mismatch("cam_resetb_o", cyc >= CAM_RESET_CYCLES, cam_resetb_o);
		end
		apb_check_read(ADDR_STATUS, 32'h101);
		end_test("camera sequence", e0);

		// register access
		e0 = errors;
		apb_write(ADDR_VIEW, 32'h3);
		apb_check_read(ADDR_VIEW, 32'h3);
		apb_check_read(ADDR_STATUS, 32'h101);   // no sop yet
		apb_write(4'h8, 32'h2);
		apb_check_read(ADDR_VIEW, 32'h3);
		apb_check_read(4'h8, 32'h0);
		end_test("apb registers", e0);

		// view change mid-frame waits for the next sop
		e0 = errors;
		apb_write(ADDR_VIEW, 32'h1);
		run_frame(20, -1, 4'h0);
		drain_words();
		run_frame(24, 6, 4'h2);
		drain_words();
		apb_check_read(ADDR_STATUS, 32'h101);
		apb_check_read(ADDR_VIEW, 32'h2);
		run_frame(20, -1, 4'h0);
		drain_words();
		apb_check_read(ADDR_STATUS, 32'h102);
		end_test("per-frame latching", e0);

		// each view code
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			apb_write(ADDR_VIEW, {28'h0, codes[i]});
			run_frame(16 + rand_bits(6) % 49, -1, 4'h0);
			drain_words();
			apb_check_read(ADDR_STATUS, {23'h0, 1'b1, 4'h0, codes[i]});
		end
		end_test("view contents", e0);

		// odd frame leaves a pixel that the next sop drops
		e0 = errors;
		apb_write(ADDR_VIEW, 32'h3);
		run_frame(17, -1, 4'h0);
		drain_words();
		run_frame(20, -1, 4'h0);
		drain_words();
		run_frame(33, -1, 4'h0);
		drain_words();
		run_frame(16 + rand_bits(6) % 49, -1, 4'h0);
		drain_words();
		end_test("word packing", e0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sources.f */
logic/hdr_pkg.sv
logic/cam_power_seq.sv
logic/hdr_cfg_regs.sv
logic/view_select.sv
logic/ddr_word_pack.sv
logic/hdr_video_top.sv
test/tb_hdr_video.sv
